// File: hdl/mult_arith_pkg.sv
`default_nettype none

package mult_arith_pkg;

    // mode select encodings, one bit
    localparam logic SIGNED_MODE   = 1'b1;
    localparam logic UNSIGNED_MODE = 1'b0;

    // iteration counter width for a given operand width
    // counter runs 0 .. op_width-1, so clog2 is enough
    function automatic int count_width(input int op_width);
        int width;
        begin
            if (op_width > 1)
            begin
                width = $clog2(op_width);
            end
            else
            begin
                width = 1; // degenerate single-bit case
            end
            return width;
        end
    endfunction

endpackage

`default_nettype wire

// File: hdl/mult_regmap_pkg.sv
`default_nettype none

package mult_regmap_pkg;

    localparam int ADDR_WIDTH = 3; // word address

    // word addresses
    localparam logic [ADDR_WIDTH-1:0] REG_OP_A    = 3'd0;
    localparam logic [ADDR_WIDTH-1:0] REG_OP_B    = 3'd1;
    localparam logic [ADDR_WIDTH-1:0] REG_CTRL    = 3'd2;
    localparam logic [ADDR_WIDTH-1:0] REG_PROD_LO = 3'd3;
    localparam logic [ADDR_WIDTH-1:0] REG_PROD_HI = 3'd4;

    // write view of the control word
    typedef struct packed {
        logic [29:0] reserved;
        logic        signed_mode; // 1 = two's complement operands
        logic        start;       // kick off an operation
    } ctrl_cmd_t;

    // read view of the same word
    typedef struct packed {
        logic [28:0] reserved;
        logic        last_signed; // mode of the held product
        logic        done;
        logic        busy;
    } ctrl_status_t;

    // one word, decoded as command on write and status on read
    typedef union packed {
        ctrl_cmd_t    cmd;
        ctrl_status_t status;
    } ctrl_word_u;

endpackage

`default_nettype wire

// File: hdl/wb_mult_slave.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mult_slave #(
    parameter int OP_WIDTH = 32
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cyc,
    input  logic                                  stb,
    input  logic                                  we,
    input  logic [mult_regmap_pkg::ADDR_WIDTH-1:0] adr,
    input  logic [OP_WIDTH-1:0]                   dat_w,
    input  logic [OP_WIDTH-1:0]                   prod_lo,
    input  logic [OP_WIDTH-1:0]                   prod_hi,
    input  wire  mult_regmap_pkg::ctrl_word_u     status,
    output logic [OP_WIDTH-1:0]                   dat_r,
    output logic                                  ack,
    output logic [OP_WIDTH-1:0]                   op_a,
    output logic [OP_WIDTH-1:0]                   op_b,
    output logic                                  signed_mode,
    output logic                                  start
);

    localparam int CTRL_W = $bits(mult_regmap_pkg::ctrl_word_u);

    logic                        accept;      // first cycle of a new transfer
    logic                        ctrl_write;
    logic [CTRL_W-1:0]           status_bits;
    logic [OP_WIDTH-1:0]         rd_mux;
    mult_regmap_pkg::ctrl_word_u cmd_word;

    assign accept      = cyc && stb && !ack; // no new transfer until ack drops
    assign cmd_word    = CTRL_W'(dat_w);     // zero-extend for narrow buses
    assign status_bits = status;
    assign ctrl_write  = accept && we && (adr == mult_regmap_pkg::REG_CTRL);

    // single-cycle registered ack, start lands in the ack cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack   <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            ack   <= accept;
            start <= ctrl_write && cmd_word.cmd.start;
        end
    end

    // operand and mode registers, written at acceptance
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            op_a        <= '0;
            op_b        <= '0;
            signed_mode <= 1'b0;
        end
        else if (accept && we)
        begin
            case (adr)
                mult_regmap_pkg::REG_OP_A: op_a <= dat_w;
                mult_regmap_pkg::REG_OP_B: op_b <= dat_w;
                mult_regmap_pkg::REG_CTRL: signed_mode <= cmd_word.cmd.signed_mode;
                default: ; // read-only or reserved
            endcase
        end
    end

    always_comb
    begin
        case (adr)
            mult_regmap_pkg::REG_OP_A:    rd_mux = op_a;
            mult_regmap_pkg::REG_OP_B:    rd_mux = op_b;
            mult_regmap_pkg::REG_CTRL:    rd_mux = OP_WIDTH'(status_bits); // status view
            mult_regmap_pkg::REG_PROD_LO: rd_mux = prod_lo;
            mult_regmap_pkg::REG_PROD_HI: rd_mux = prod_hi;
            default:                      rd_mux = '0; // reserved reads as zero
        endcase
    end

    // read data is valid together with ack
    always_ff @(posedge clk)
    begin
        if (accept && !we)
        begin
            dat_r <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: hdl/shift_add_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module shift_add_multiplier #(
    parameter int OP_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  signed_mode,
    input  logic [OP_WIDTH-1:0]   op_a,
    input  logic [OP_WIDTH-1:0]   op_b,
    output logic [2*OP_WIDTH-1:0] product,
    output logic                  product_valid,
    output logic                  busy
);

    localparam int CNT_W = mult_arith_pkg::count_width(OP_WIDTH);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(OP_WIDTH - 1);

    logic                  a_neg;
    logic                  b_neg;
    logic [OP_WIDTH-1:0]   abs_a;
    logic [OP_WIDTH-1:0]   abs_b;
    logic                  result_neg;

    logic [2*OP_WIDTH-1:0] multiplicand; // shifts left each step
    logic [OP_WIDTH-1:0]   multiplier;   // shifts right each step
    logic [2*OP_WIDTH-1:0] acc;
    logic [2*OP_WIDTH-1:0] partial;
    logic                  neg;          // sign of the final result
    logic [CNT_W-1:0]      count;

    // operand sign only matters in signed mode
    assign a_neg = (signed_mode == mult_arith_pkg::SIGNED_MODE) && op_a[OP_WIDTH-1];
    assign b_neg = (signed_mode == mult_arith_pkg::SIGNED_MODE) && op_b[OP_WIDTH-1];
    assign abs_a = a_neg ? (~op_a + 1'b1) : op_a;
    assign abs_b = b_neg ? (~op_b + 1'b1) : op_b;
    assign result_neg = a_neg ^ b_neg; // always 0 in unsigned mode

    assign partial = multiplier[0] ? multiplicand : '0;

    // fixed count of OP_WIDTH iterations
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy          <= 1'b0;
            product_valid <= 1'b0;
            count         <= '0;
        end
        else
        begin
            product_valid <= 1'b0;
            if (busy)
            begin
                count <= count + 1'b1;
                if (count == LAST_STEP)
                begin
                    busy          <= 1'b0;
                    product_valid <= 1'b1; // acc is final in this cycle
                end
            end
            else if (start)
            begin
                busy  <= 1'b1;
                count <= '0;
            end
        end
    end

    // datapath ignores start while busy
    always_ff @(posedge clk)
    begin
        if (busy)
        begin
            acc          <= acc + partial;
            multiplicand <= {multiplicand[2*OP_WIDTH-2:0], 1'b0};
            multiplier   <= {1'b0, multiplier[OP_WIDTH-1:1]};
        end
        else if (start)
        begin
            multiplicand <= {{OP_WIDTH{1'b0}}, abs_a};
            multiplier   <= abs_b;
            acc          <= '0;
            neg          <= result_neg;
        end
    end

    assign product = neg ? (~acc + 1'b1) : acc; // apply sign at the end

endmodule

`default_nettype wire

// File: hdl/mult_result_regs.sv
`timescale 1ns/100ps
`default_nettype none

module mult_result_regs #(
    parameter int OP_WIDTH = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [2*OP_WIDTH-1:0]       product,
    input  logic                        product_valid,
    input  logic                        busy,
    input  logic                        start,
    input  logic                        signed_mode,
    output logic [OP_WIDTH-1:0]         prod_lo,
    output logic [OP_WIDTH-1:0]         prod_hi,
    output mult_regmap_pkg::ctrl_word_u status
);

    logic [2*OP_WIDTH-1:0] prod_reg;
    logic                  done;
    logic                  pending_mode; // mode of the operation in flight
    logic                  last_signed;
    logic                  start_taken;

    assign start_taken = start && !busy; // same rule the core applies

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prod_reg     <= '0;
            done         <= 1'b0;
            pending_mode <= 1'b0;
            last_signed  <= 1'b0;
        end
        else
        begin
            if (start_taken)
            begin
                pending_mode <= signed_mode;
                done         <= 1'b0;
            end
            if (product_valid)
            begin
                prod_reg    <= product;
                last_signed <= (pending_mode == mult_arith_pkg::SIGNED_MODE);
                done        <= 1'b1; // visible the cycle after valid
            end
        end
    end

    assign prod_lo = prod_reg[OP_WIDTH-1:0];
    assign prod_hi = prod_reg[2*OP_WIDTH-1:OP_WIDTH];

    // status view of the control word
    always_comb
    begin
        status                    = '0;
        status.status.busy        = busy;
        status.status.done        = done;
        status.status.last_signed = last_signed;
    end

endmodule

`default_nettype wire

// File: hdl/wb_multiplier_top.sv
`timescale 1ns/100ps
`default_nettype none

module wb_multiplier_top #(
    parameter int OP_WIDTH = 32
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cyc,
    input  logic                                  stb,
    input  logic                                  we,
    input  logic [mult_regmap_pkg::ADDR_WIDTH-1:0] adr,
    input  logic [OP_WIDTH-1:0]                   dat_w,
    output logic [OP_WIDTH-1:0]                   dat_r,
    output logic                                  ack
);

    logic [OP_WIDTH-1:0]         op_a;
    logic [OP_WIDTH-1:0]         op_b;
    logic                        signed_mode;
    logic                        start;
    logic [2*OP_WIDTH-1:0]       product;
    logic                        product_valid;
    logic                        busy;
    logic [OP_WIDTH-1:0]         prod_lo;
    logic [OP_WIDTH-1:0]         prod_hi;
    mult_regmap_pkg::ctrl_word_u status;

    wb_mult_slave #(.OP_WIDTH(OP_WIDTH)) u_slave (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .prod_lo(prod_lo), .prod_hi(prod_hi), .status(status),
        .dat_r(dat_r), .ack(ack),
        .op_a(op_a), .op_b(op_b), .signed_mode(signed_mode), .start(start)
    );

    shift_add_multiplier #(.OP_WIDTH(OP_WIDTH)) u_core (
        .clk(clk), .reset(reset),
        .start(start), .signed_mode(signed_mode), .op_a(op_a), .op_b(op_b),
        .product(product), .product_valid(product_valid), .busy(busy)
    );

    mult_result_regs #(.OP_WIDTH(OP_WIDTH)) u_result (
        .clk(clk), .reset(reset),
        .product(product), .product_valid(product_valid), .busy(busy),
        .start(start), .signed_mode(signed_mode),
        .prod_lo(prod_lo), .prod_hi(prod_hi), .status(status)
    );

endmodule

`default_nettype wire

// File: tests/wb_multiplier_chk.sv
`timescale 1ns/100ps
`default_nettype none

module wb_multiplier_chk #(
    parameter int OP_WIDTH = 32
) (
    input logic                        clk,
    input logic                        reset,
    input logic                        cyc,
    input logic                        stb,
    input logic                        ack,
    input logic                        busy,
    input mult_regmap_pkg::ctrl_word_u status
);

    int busy_len; // consecutive busy cycles so far

    always_ff @(posedge clk)
    begin
        if (reset || !busy)
            busy_len <= 0;
        else
            busy_len <= busy_len + 1;
    end

    ack_with_request: assert property (@(posedge clk) disable iff (reset)
        ack |-> (cyc && stb)) else $error("ack outside an active request");

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack) else $error("ack held for two cycles");

    busy_done_apart: assert property (@(posedge clk) disable iff (reset)
        !(busy && status.status.done)) else $error("busy and done both set");

    busy_length: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> (busy_len == OP_WIDTH)) else $error("busy length wrong");

endmodule

bind wb_multiplier_top wb_multiplier_chk #(.OP_WIDTH(OP_WIDTH)) u_chk (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .ack(ack),
    .busy(busy), .status(status)
);

`default_nettype wire

// File: tests/wb_multiplier_tb.sv
`timescale 1ns/100ps
`default_nettype none

module wb_multiplier_tb;

    localparam int OP_WIDTH    = 32;
    localparam int NUM_CASES   = 11;
    localparam int NUM_RANDOM  = 32;
    localparam int NUM_OPS     = NUM_CASES + NUM_RANDOM + 2; // plus the busy-start pair
    localparam int CYCLE_LIMIT = NUM_OPS * (OP_WIDTH + 2 + 12) + 500;
    localparam logic [31:0] LFSR_SEED = 32'd4414;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
    localparam logic S = mult_arith_pkg::SIGNED_MODE;
    localparam logic U = mult_arith_pkg::UNSIGNED_MODE;

    // operand a, operand b, mode, expected product
    localparam logic [128:0] CASE_TABLE [0:NUM_CASES-1] = '{
        {32'h0000_0000, 32'h0001_E240, S, 64'h0000_0000_0000_0000},
        {32'h0000_0001, 32'h0000_0001, U, 64'h0000_0000_0000_0001},
        {32'hFFFF_FFFF, 32'hFFFF_FFFF, S, 64'h0000_0000_0000_0001},
        {32'h8000_0000, 32'hFFFF_FFFF, S, 64'h0000_0000_8000_0000},
        {32'hFFFF_FFFF, 32'hFFFF_FFFF, U, 64'hFFFF_FFFE_0000_0001},
        {32'hFFFF_FFFD, 32'h0000_0007, S, 64'hFFFF_FFFF_FFFF_FFEB},
        {32'h0000_0007, 32'hFFFF_FFFD, S, 64'hFFFF_FFFF_FFFF_FFEB},
        {32'h8000_0000, 32'hFFFF_FFFF, U, 64'h7FFF_FFFF_8000_0000},
        {32'h8000_0000, 32'h8000_0000, S, 64'h4000_0000_0000_0000},
        {32'h0001_0000, 32'h0001_0000, U, 64'h0000_0001_0000_0000},
        {32'hFFFF_FFFD, 32'h0000_0007, U, 64'h0000_0006_FFFF_FFEB}
    };

    logic                                   clk;
    logic                                   reset;
    logic                                   cyc;
    logic                                   stb;
    logic                                   we;
    logic [mult_regmap_pkg::ADDR_WIDTH-1:0] adr;
    logic [OP_WIDTH-1:0]                    dat_w;
    logic [OP_WIDTH-1:0]                    dat_r;
    logic                                   ack;

    int          cycles = 0;
    int          ack_count = 0;
    int          transfers = 0;
    int          last_ack_cycle = 0;
    logic [31:0] lfsr_state;

    wb_multiplier_top #(.OP_WIDTH(OP_WIDTH)) uut (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (ack)
            ack_count <= ack_count + 1; // one per acknowledged cycle
    end

    initial
    begin
        wait (cycles >= CYCLE_LIMIT);
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        begin
            next = state >> 1;
            if (state[0])
                next = next ^ LFSR_TAPS;
            return next;
        end
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        begin
            value = '0;
            for (int k = 0; k < count; k++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                value      = {value[30:0], lfsr_state[0]}; // one step per bit
            end
        end
    endtask

    function automatic logic [63:0] expected_product(input logic [31:0] a,
                                                     input logic [31:0] b,
                                                     input logic mode);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        begin
            sa = {{32{a[31]}}, a};
            sb = {{32{b[31]}}, b};
            if (mode == mult_arith_pkg::SIGNED_MODE)
                return sa * sb;
            return {32'b0, a} * {32'b0, b};
        end
    endfunction

    // command view: bit 0 start, bit 1 signed mode
    function automatic logic [31:0] ctrl_word(input logic mode, input logic go);
        return {30'b0, mode, go};
    endfunction

    // status view: bit 0 busy, bit 1 done, bit 2 last signed
    function automatic logic [31:0] status_word(input logic busy, input logic done,
                                                input logic last_signed);
        return {29'b0, last_signed, done, busy};
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        begin
            if (actual !== expected)
            begin
                $display("Error at %0t ns: %s: read %h, expected %h",
                         $time, what, actual, expected);
                $display("TEST FAILED");
                $fatal(1);
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after the ack cycle
    task automatic bus_transfer(input logic write,
                                input logic [mult_regmap_pkg::ADDR_WIDTH-1:0] address,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        begin
            cyc   = 1'b1;
            stb   = 1'b1;
            we    = write;
            adr   = address;
            dat_w = wdata;
            @(negedge clk);
            while (!ack)
                @(negedge clk);
            rdata          = dat_r;
            last_ack_cycle = cycles;
            transfers      = transfers + 1;
            @(negedge clk); // hold the request through the ack edge
            cyc = 1'b0;
            stb = 1'b0;
            we  = 1'b0;
        end
    endtask

    task automatic bus_write(input logic [mult_regmap_pkg::ADDR_WIDTH-1:0] address,
                             input logic [31:0] data);
        logic [31:0] unused;
        begin
            bus_transfer(1'b1, address, data, unused);
        end
    endtask

    task automatic bus_read(input logic [mult_regmap_pkg::ADDR_WIDTH-1:0] address,
                            output logic [31:0] data);
        begin
            bus_transfer(1'b0, address, 32'h0, data);
        end
    endtask

    task automatic start_operation(input logic [31:0] a, input logic [31:0] b,
                                   input logic mode, input string tag, output int start_cycle);
        logic [31:0] rd;
        begin
            bus_write(mult_regmap_pkg::REG_OP_A, a);
            bus_write(mult_regmap_pkg::REG_OP_B, b);
            bus_write(mult_regmap_pkg::REG_CTRL, ctrl_word(mode, 1'b1));
            start_cycle = last_ack_cycle;
            bus_read(mult_regmap_pkg::REG_CTRL, rd);
            check(64'(rd[1:0]), 64'h1, {tag, " status while busy"});
        end
    endtask

    // done is readable OP_WIDTH + 2 cycles after the start ack
    task automatic read_result(input int start_cycle, input logic mode,
                               input logic [63:0] expected, input string tag);
        logic [31:0] rd;
        logic [31:0] lo;
        logic [31:0] hi;
        begin
            while (cycles < start_cycle + OP_WIDTH + 2)
                @(negedge clk);
            bus_read(mult_regmap_pkg::REG_CTRL, rd);
            check(64'(rd), 64'(status_word(1'b0, 1'b1, mode)), {tag, " status when done"});
            bus_read(mult_regmap_pkg::REG_PROD_LO, lo);
            bus_read(mult_regmap_pkg::REG_PROD_HI, hi);
            check({hi, lo}, expected, {tag, " product"});
        end
    endtask

    initial
    begin
        int            start_cycle;
        logic [128:0]  row;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   rd;
        logic [31:0]   bits;
        logic          mode;

        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        reset      = 1'b1;
        lfsr_state = LFSR_SEED;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        bus_read(mult_regmap_pkg::REG_CTRL, rd);
        check(64'(rd), 64'h0, "status after reset");
        bus_read(mult_regmap_pkg::REG_PROD_LO, rd);
        check(64'(rd), 64'h0, "product low after reset");
        bus_read(mult_regmap_pkg::REG_PROD_HI, rd);
        check(64'(rd), 64'h0, "product high after reset");

        for (int i = 0; i < NUM_CASES; i++)
        begin
            row = CASE_TABLE[i];
            start_operation(row[128:97], row[96:65], row[64], $sformatf("case %0d", i),
                            start_cycle);
            read_result(start_cycle, row[64], row[63:0], $sformatf("case %0d", i));
        end

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            draw_bits(32, a);
            draw_bits(32, b);
            draw_bits(1, bits);
            mode = bits[0];
            start_operation(a, b, mode, $sformatf("random %0d", i), start_cycle);
            read_result(start_cycle, mode, expected_product(a, b, mode),
                        $sformatf("random %0d", i));
        end

        // second start while busy is dropped, new operands wait for the next start
        start_operation(32'h0000_1234, 32'hFFFF_FFF0, S, "busy first", start_cycle);
        bus_write(mult_regmap_pkg::REG_OP_A, 32'hC000_0001);
        bus_write(mult_regmap_pkg::REG_OP_B, 32'h0000_0300);
        bus_write(mult_regmap_pkg::REG_CTRL, ctrl_word(U, 1'b1));
        read_result(start_cycle, S, expected_product(32'h0000_1234, 32'hFFFF_FFF0, S),
                    "busy first");
        bus_write(mult_regmap_pkg::REG_CTRL, ctrl_word(U, 1'b1));
        start_cycle = last_ack_cycle;
        read_result(start_cycle, U, expected_product(32'hC000_0001, 32'h0000_0300, U),
                    "busy second");

        for (int r = 5; r < 8; r++)
        begin
            bus_read(3'(r), rd);
            check(64'(rd), 64'h0, $sformatf("reserved address %0d", r));
        end

        repeat (2) @(negedge clk);
        check(64'(ack_count), 64'(transfers), "acknowledge count");
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_multiplier.f
hdl/mult_arith_pkg.sv
hdl/mult_regmap_pkg.sv
hdl/wb_mult_slave.sv
hdl/shift_add_multiplier.sv
hdl/mult_result_regs.sv
hdl/wb_multiplier_top.sv
tests/wb_multiplier_chk.sv
tests/wb_multiplier_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the multiplier testbench with Verilator, run it and check the log

BUILD_DIR=obj_dir
SIM_BIN=wb_multiplier_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module wb_multiplier_tb -f wb_multiplier.f \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
